// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := gpio_decoder_tb
FILELIST  := list.f

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf obj_dir

// ==== dv/gpio_decoder_properties.sv ====
// bound into the register file; sees the captured access, two edges behind the host strobe
`timescale 1ns/1ps

module gpio_decoder_properties (
    input logic                reset_in,
    input logic                write_address,
    input logic                wr_i,
    input logic                rd_i,
    input gpio_pkg::bus_word_t read_data_i
);

    // captured strobes last one cycle
    wr_pulse: assert property (@(posedge reset_in) disable iff (write_address) wr_i |=> !wr_i)
        else $error("write strobe held high for more than one cycle");
    rd_pulse: assert property (@(posedge reset_in) disable iff (write_address) rd_i |=> !rd_i)
        else $error("read strobe held high for more than one cycle");

    // rd trails the host strobe by two edges, the load is the third
    rd_latency: assert property (@(posedge reset_in) disable iff (write_address)
        !$stable(read_data_i) |-> $past(rd_i))
        else $error("read data changed without a read strobe three cycles before");

endmodule

bind gpio_reg_file gpio_decoder_properties u_props (
    .reset_in      (reset_in),
    .write_address (write_address),
    .wr_i          (bus.wr),
    .rd_i          (bus.rd),
    .read_data_i   (read_data_o)
);

// ==== dv/gpio_decoder_tb.sv ====
// fixed latencies from strobe to check; every access waits out the pipeline before the next
`timescale 1ns/1ps
`include "gpio_consts.svh"

module gpio_decoder_tb;
    import gpio_pkg::*;

    localparam logic [1:0] OP_WR   = 2'd0;
    localparam logic [1:0] OP_RD   = 2'd1;
    localparam logic [1:0] OP_PIN  = 2'd2;
    localparam logic [1:0] OP_WRRD = 2'd3;
    // what the host returns for addresses outside the block
    localparam bus_word_t HM2_WORD = 32'hc0de_5a5a;

    // one table row
    typedef struct packed {
        logic [1:0] op;
        bus_addr_t  addr;
        bus_word_t  data;
        pin_vec_t   host;
        bus_word_t  exp_word;
        pin_vec_t   exp_out;
        pin_vec_t   exp_oe;
    } entry_t;

    logic      reset_in;
    logic      write_address;
    logic      write_reg;
    logic      read_reg;
    bus_addr_t bus_addr;
    bus_word_t bus_data;
    bus_word_t hm2_data;
    pin_vec_t  hm3_data;
    pin_vec_t  pin_in;
    pin_vec_t  pin_out;
    pin_vec_t  pin_oe;
    bus_word_t read_data;

    entry_t tbl [$];
    string  names [$];
    // expected configuration, tracked while the table is built
    int       sel_m [`GPIO_NUM_PINS];
    pin_vec_t ddr_m;
    pin_vec_t od_m;
    pin_vec_t pin_in_v;
    logic     table_ready;
    int       n_checks;
    int       n_errors;

    tb_clock #(.PERIOD(20), .RESET_CYCLES(3)) u_clock (
        .clock_o (reset_in),
        .reset_o (write_address)
    );

    gpio_decoder_top DUT (
        .reset_in      (reset_in),
        .write_address (write_address),
        .write_reg_i   (write_reg),
        .read_reg_i    (read_reg),
        .bus_addr_i    (bus_addr),
        .bus_data_i    (bus_data),
        .hm2_data_i    (hm2_data),
        .hm3_data_i    (hm3_data),
        .pin_in_i      (pin_in),
        .pin_out_o     (pin_out),
        .pin_oe_o      (pin_oe),
        .read_data_o   (read_data)
    );

    function automatic pin_vec_t rand_pins();
        return pin_vec_t'({$urandom(), $urandom(), $urandom()});
    endfunction

    task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end else begin
            $display("ok    %s: %h", name, act);
        end
    endtask

    task automatic check_pins(input string name, input pin_vec_t exp, input pin_vec_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end else begin
            $display("ok    %s: %h", name, act);
        end
    endtask

    // register windows as the host sees them
    function automatic void model_write(input bus_addr_t addr, input bus_word_t data);
        int off_ddr;
        int off_od;
        int off_sel;
        off_ddr = int'(addr) - `GPIO_DDR_BASE;
        off_od  = int'(addr) - `GPIO_OD_BASE;
        off_sel = int'(addr) - `GPIO_SEL_BASE;
        if (off_ddr >= 0 && off_ddr < 4 * `GPIO_NUM_REGS) begin
            ddr_m[(off_ddr / 4) * `GPIO_REG_W +: `GPIO_REG_W] = data[`GPIO_REG_W-1:0];
        end
        if (off_od >= 0 && off_od < 4 * `GPIO_NUM_REGS) begin
            od_m[(off_od / 4) * `GPIO_REG_W +: `GPIO_REG_W] = data[`GPIO_REG_W-1:0];
        end
        // byte offset of word w is also its first pin
        if (off_sel >= 0 && off_sel < 4 * `GPIO_NUM_SEL_REGS) begin
            for (int b = 0; b < 4; b++) begin
                sel_m[off_sel + b] = int'(data[8*b +: 8]);
            end
        end
    endfunction

    function automatic void push(input string name, input logic [1:0] op, input bus_addr_t addr,
                                 input bus_word_t data, input bus_word_t exp_word);
        entry_t e;
        e = '0;
        e.op       = op;
        e.addr     = addr;
        e.data     = data;
        e.exp_word = exp_word;
        if (op == OP_WR || op == OP_WRRD) begin
            model_write(addr, data);
        end
        tbl.push_back(e);
        names.push_back(name);
    endfunction

    // open-drain pulls low only, else push-pull under DDR
    function automatic void push_pins(input string name, input pin_vec_t host);
        entry_t e;
        logic   c;
        e = '0;
        e.op   = OP_PIN;
        e.host = host;
        for (int p = 0; p < `GPIO_NUM_PINS; p++) begin
            c = (sel_m[p] < `GPIO_NUM_PINS) ? host[sel_m[p]] : 1'b0;
            e.exp_out[p] = od_m[p] ? 1'b0 : c;
            e.exp_oe[p]  = od_m[p] ? ~c : ddr_m[p];
        end
        tbl.push_back(e);
        names.push_back(name);
    endfunction

    function automatic void build_table();
        pin_vec_t host_v;
        for (int p = 0; p < `GPIO_NUM_PINS; p++) begin
            sel_m[p] = p;
        end
        ddr_m = '0;
        od_m  = '0;
        push_pins("pins_after_reset", rand_pins());
        push("sel0_reset", OP_RD, `GPIO_SEL_BASE, '0, 32'h0302_0100);
        push("ddr0_reset", OP_RD, `GPIO_DDR_BASE, '0, 32'h0);
        push("ddr1_write", OP_WR, `GPIO_DDR_BASE + 16'h4, 32'ha5f0_0f5a, '0);
        push("ddr1_readback", OP_RD, `GPIO_DDR_BASE + 16'h4, '0, 32'h00f0_0f5a);
        push("od2_write", OP_WR, `GPIO_OD_BASE + 16'h8, 32'hffff_ffff, '0);
        push("od2_readback", OP_RD, `GPIO_OD_BASE + 16'h8, '0, 32'h00ff_ffff);
        push("pin_in_word1", OP_RD, `GPIO_IN_BASE + 16'h4, '0, bus_word_t'(pin_in_v[47:24]));
        push("unmapped_read", OP_RD, 16'h2000, '0, HM2_WORD);
        push("od2_clear", OP_WR, `GPIO_OD_BASE + 16'h8, 32'h0, '0);
        for (int r = 0; r < `GPIO_NUM_REGS; r++) begin
            push($sformatf("ddr%0d_all", r), OP_WR, `GPIO_DDR_BASE + 16'(4 * r),
                 32'h00ff_ffff, '0);
        end
        push_pins("identity_routing", rand_pins());
        // pin 0 from 71, pin 1 from 40, pin 2 out of range, pin 3 from 5
        push("sel0_rewrite", OP_WR, `GPIO_SEL_BASE, {8'd5, 8'd80, 8'd40, 8'd71}, '0);
        push("od0_pins_0_2", OP_WR, `GPIO_OD_BASE, 32'h0000_0005, '0);
        host_v = rand_pins();
        push_pins("remap_open_drain_a", host_v);
        // complement, so every routed source is seen both high and low
        push_pins("remap_open_drain_b", ~host_v);
        push("b2b_sel1", OP_WRRD, `GPIO_SEL_BASE + 16'h4, 32'h1122_3344, 32'h1122_3344);
        push("b2b_ddr2", OP_WRRD, `GPIO_DDR_BASE + 16'h8, 32'h1234_5678, 32'h0034_5678);
    endfunction

    task automatic drive_strobe(input logic wr, input logic rd, input bus_addr_t addr,
                                input bus_word_t data);
        write_reg <= wr;
        read_reg  <= rd;
        bus_addr  <= addr;
        bus_data  <= data;
    endtask

    task automatic run_entry(input int i);
        entry_t e;
        e = tbl[i];
        @(posedge reset_in);
        if (e.op == OP_PIN) begin
            hm3_data <= e.host;
            repeat (2) @(posedge reset_in);
            @(negedge reset_in);
            check_pins({names[i], ".out"}, e.exp_out, pin_out);
            check_pins({names[i], ".oe"}, e.exp_oe, pin_oe);
        end else begin
            drive_strobe(e.op != OP_RD, e.op == OP_RD, e.addr, e.data);
            @(posedge reset_in);
            // read follows the write on the very next cycle
            if (e.op == OP_WRRD) begin
                drive_strobe(1'b0, 1'b1, e.addr, e.data);
                @(posedge reset_in);
            end
            drive_strobe(1'b0, 1'b0, e.addr, e.data);
            repeat (3) @(posedge reset_in);
            @(negedge reset_in);
            if (e.op == OP_WR) begin
                $display("done  %s", names[i]);
            end else begin
                check_word(names[i], e.exp_word, read_data);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h83e13a03));
        n_checks    = 0;
        n_errors    = 0;
        table_ready = 1'b0;
        pin_in_v    = rand_pins();
        write_reg   = 1'b0;
        read_reg    = 1'b0;
        bus_addr    = '0;
        bus_data    = '0;
        hm2_data    = HM2_WORD;
        hm3_data    = '0;
        pin_in      = pin_in_v;
        build_table();
        table_ready = 1'b1;
        @(negedge write_address);
        for (int i = 0; i < tbl.size(); i++) begin
            run_entry(i);
        end
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // ten cycles per row is well above the longest row
    initial begin
        wait (table_ready);
        repeat (tbl.size() * 10) @(posedge reset_in);
        $display("timeout: table did not finish within %0d cycles", tbl.size() * 10);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== dv/tb_clock.sv ====
// free-running clock from time zero; reset is released on a falling edge, clear of the flops
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clock_o,
    output logic reset_o
);

    initial begin
        clock_o = 1'b0;
        forever #(PERIOD / 2) clock_o = ~clock_o;
    end

    // held for whole cycles, dropped half a period later
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock_o);
        @(negedge clock_o);
        reset_o = 1'b0;
    end

endmodule

// ==== hdl/bus_strobe_sync.sv ====
// strobes must be single-cycle pulses; the access reaches the register file two edges later
`timescale 1ns/1ps
`include "gpio_consts.svh"

module bus_strobe_sync (
    input  logic               reset_in,
    input  logic               write_address,
    input  logic               write_reg_i,
    input  logic               read_reg_i,
    input  gpio_pkg::bus_addr_t bus_addr_i,
    input  gpio_pkg::bus_word_t bus_data_i,
    gpio_bus_if.source         bus
);
    import gpio_pkg::*;

    // one stage short of the latency, the last edge is the commit
    localparam int DEPTH = `GPIO_BUS_LAT - 1;

    // strobe pipeline
    logic [DEPTH-1:0] wr_q;
    logic [DEPTH-1:0] rd_q;

    // payload pipeline, shifts along with the strobes
    bus_addr_t addr_q [DEPTH];
    bus_word_t data_q [DEPTH];

    // strobes, cleared on reset
    always_ff @(posedge reset_in or posedge write_address) begin
        if (write_address) begin
            wr_q <= '0;
            rd_q <= '0;
        end else begin
            wr_q <= {wr_q[DEPTH-2:0], write_reg_i};
            rd_q <= {rd_q[DEPTH-2:0], read_reg_i};
        end
    end

    // address and data
    always_ff @(posedge reset_in) begin
        // word align on the way in
        addr_q[0] <= {bus_addr_i[`GPIO_ADDR_W-1:2], 2'b00};
        data_q[0] <= bus_data_i;
        for (int s = 1; s < DEPTH; s++) begin
            addr_q[s] <= addr_q[s-1];
            data_q[s] <= data_q[s-1];
        end
    end

    // last stage drives the register file
    assign bus.wr    = wr_q[DEPTH-1];
    assign bus.rd    = rd_q[DEPTH-1];
    assign bus.addr  = addr_q[DEPTH-1];
    assign bus.wdata = data_q[DEPTH-1];

endmodule

// ==== hdl/gpio_bus_if.sv ====
// one captured access per cycle, no back-pressure; addr and wdata only meaningful with a strobe
`timescale 1ns/1ps

interface gpio_bus_if;
    import gpio_pkg::*;

    // single-cycle strobes
    logic      wr;
    logic      rd;

    // travel with the strobe, same cycle
    bus_addr_t addr;
    bus_word_t wdata;

    // capture side
    modport source (
        output wr, rd, addr, wdata
    );

    // register file side
    modport sink (
        input  wr, rd, addr, wdata
    );

endinterface

// ==== hdl/gpio_decoder_top.sv ====
// pins split into out, oe and in for simulation without tri-states; single clock domain
`timescale 1ns/1ps
`include "gpio_consts.svh"

module gpio_decoder_top (
    // clock, reset, host bus
    input  logic                reset_in,
    input  logic                write_address,
    input  logic                write_reg_i,
    input  logic                read_reg_i,
    input  gpio_pkg::bus_addr_t bus_addr_i,
    input  gpio_pkg::bus_word_t bus_data_i,
    input  gpio_pkg::bus_word_t hm2_data_i,
    // pins
    input  gpio_pkg::pin_vec_t  hm3_data_i,
    input  gpio_pkg::pin_vec_t  pin_in_i,
    output gpio_pkg::pin_vec_t  pin_out_o,
    output gpio_pkg::pin_vec_t  pin_oe_o,
    // read data back to the host
    output gpio_pkg::bus_word_t read_data_o
);
    import gpio_pkg::*;

    // register file to pin mux
    pin_vec_t  ddr;
    pin_vec_t  od;
    port_sel_t port_sel [`GPIO_NUM_PINS];

    // captured access
    gpio_bus_if bus_if ();

    bus_strobe_sync u_sync (
        .reset_in      (reset_in),
        .write_address (write_address),
        .write_reg_i   (write_reg_i),
        .read_reg_i    (read_reg_i),
        .bus_addr_i    (bus_addr_i),
        .bus_data_i    (bus_data_i),
        .bus           (bus_if.source)
    );

    gpio_reg_file u_regs (
        .reset_in      (reset_in),
        .write_address (write_address),
        .bus           (bus_if.sink),
        .hm2_data_i    (hm2_data_i),
        .pin_in_i      (pin_in_i),
        .ddr_o         (ddr),
        .od_o          (od),
        .port_sel_o    (port_sel),
        .read_data_o   (read_data_o)
    );

    pin_mux u_mux (
        .reset_in      (reset_in),
        .write_address (write_address),
        .hm3_data_i    (hm3_data_i),
        .ddr_i         (ddr),
        .od_i          (od),
        .port_sel_i    (port_sel),
        .pin_out_o     (pin_out_o),
        .pin_oe_o      (pin_oe_o)
    );

endmodule

// ==== hdl/gpio_pkg.sv ====
// plain vector types only; widths track gpio_consts.svh, addresses are kept word aligned by users
`include "gpio_consts.svh"

package gpio_pkg;

    // one host bus data word
    typedef logic [`GPIO_BUS_W-1:0] bus_word_t;

    // byte address of a word, bits [1:0] held at zero
    typedef logic [`GPIO_ADDR_W-1:0] bus_addr_t;

    // one bit per pin, both banks
    // bank 0 is bits 35:0, bank 1 is bits 71:36
    typedef logic [`GPIO_NUM_PINS-1:0] pin_vec_t;

    // source index of one pin into the host output vector
    // values of 72 and up select a constant 0
    typedef logic [`GPIO_SEL_W-1:0] port_sel_t;

    // one DDR, open-drain or pin input word
    typedef logic [`GPIO_REG_W-1:0] reg_word_t;

endpackage

// ==== hdl/gpio_reg_file.sv ====
// 3 DDR, 3 open-drain, 18 port-select words; pin input words are read only, other reads pass hm2
`timescale 1ns/1ps
`include "gpio_consts.svh"

module gpio_reg_file (
    input  logic                reset_in,
    input  logic                write_address,
    gpio_bus_if.sink            bus,
    input  gpio_pkg::bus_word_t hm2_data_i,
    input  gpio_pkg::pin_vec_t  pin_in_i,
    output gpio_pkg::pin_vec_t  ddr_o,
    output gpio_pkg::pin_vec_t  od_o,
    output gpio_pkg::port_sel_t port_sel_o [`GPIO_NUM_PINS],
    output gpio_pkg::bus_word_t read_data_o
);
    import gpio_pkg::*;

    // four selects per bus word
    localparam int SEL_PER_WORD = `GPIO_BUS_W / `GPIO_SEL_W;
    // window sizes in bytes
    localparam int REG_SPAN = 4 * `GPIO_NUM_REGS;
    localparam int SEL_SPAN = 4 * `GPIO_NUM_SEL_REGS;

    // configuration storage
    reg_word_t ddr_q [`GPIO_NUM_REGS];
    reg_word_t od_q  [`GPIO_NUM_REGS];
    bus_word_t sel_q [`GPIO_NUM_SEL_REGS];

    // offsets into each window
    // below the base the subtraction wraps high, so one compare covers both ends
    bus_addr_t in_off;
    bus_addr_t ddr_off;
    bus_addr_t od_off;
    bus_addr_t sel_off;

    logic in_hit;
    logic ddr_hit;
    logic od_hit;
    logic sel_hit;

    // word index inside a window
    logic [1:0] in_idx;
    logic [1:0] ddr_idx;
    logic [1:0] od_idx;
    logic [4:0] sel_idx;

    // identity word: byte b of word w selects pin 4w+b
    function automatic bus_word_t ident_word(input int w);
        bus_word_t v;
        v = '0;
        for (int b = 0; b < SEL_PER_WORD; b++) begin
            v[b*`GPIO_SEL_W +: `GPIO_SEL_W] = port_sel_t'(SEL_PER_WORD * w + b);
        end
        return v;
    endfunction

    assign in_off  = bus.addr - bus_addr_t'(`GPIO_IN_BASE);
    assign ddr_off = bus.addr - bus_addr_t'(`GPIO_DDR_BASE);
    assign od_off  = bus.addr - bus_addr_t'(`GPIO_OD_BASE);
    assign sel_off = bus.addr - bus_addr_t'(`GPIO_SEL_BASE);

    assign in_hit  = in_off  < bus_addr_t'(REG_SPAN);
    assign ddr_hit = ddr_off < bus_addr_t'(REG_SPAN);
    assign od_hit  = od_off  < bus_addr_t'(REG_SPAN);
    assign sel_hit = sel_off < bus_addr_t'(SEL_SPAN);

    assign in_idx  = in_off[3:2];
    assign ddr_idx = ddr_off[3:2];
    assign od_idx  = od_off[3:2];
    assign sel_idx = sel_off[6:2];

    // write decode, low 24 bits for DDR and open-drain
    always_ff @(posedge reset_in or posedge write_address) begin
        if (write_address) begin
            for (int r = 0; r < `GPIO_NUM_REGS; r++) begin
                ddr_q[r] <= '0;
                od_q[r]  <= '0;
            end
            for (int w = 0; w < `GPIO_NUM_SEL_REGS; w++) begin
                sel_q[w] <= ident_word(w);
            end
        end else if (bus.wr) begin
            if (ddr_hit) begin
                ddr_q[ddr_idx] <= bus.wdata[`GPIO_REG_W-1:0];
            end
            if (od_hit) begin
                od_q[od_idx] <= bus.wdata[`GPIO_REG_W-1:0];
            end
            // whole word, four selects at once
            if (sel_hit) begin
                sel_q[sel_idx] <= bus.wdata;
            end
        end
    end

    // flatten DDR and open-drain words onto the pin vector
    for (genvar k = 0; k < `GPIO_NUM_REGS; k++) begin : g_flat
        assign ddr_o[k*`GPIO_REG_W +: `GPIO_REG_W] = ddr_q[k];
        assign od_o[k*`GPIO_REG_W +: `GPIO_REG_W]  = od_q[k];
    end

    // select register stage toward the pin mux
    always_ff @(posedge reset_in or posedge write_address) begin
        if (write_address) begin
            for (int p = 0; p < `GPIO_NUM_PINS; p++) begin
                port_sel_o[p] <= port_sel_t'(p);
            end
        end else begin
            for (int p = 0; p < `GPIO_NUM_PINS; p++) begin
                port_sel_o[p] <= sel_q[p / SEL_PER_WORD][(p % SEL_PER_WORD)*`GPIO_SEL_W +:
                                                         `GPIO_SEL_W];
            end
        end
    end

    // read mux, loaded on the read strobe and held until the next one
    always_ff @(posedge reset_in or posedge write_address) begin
        if (write_address) begin
            read_data_o <= '0;
        end else if (bus.rd) begin
            if (in_hit) begin
                // live pins, zero-extended
                read_data_o <= bus_word_t'(pin_in_i[in_idx*`GPIO_REG_W +: `GPIO_REG_W]);
            end else if (ddr_hit) begin
                read_data_o <= bus_word_t'(ddr_q[ddr_idx]);
            end else if (od_hit) begin
                read_data_o <= bus_word_t'(od_q[od_idx]);
            end else if (sel_hit) begin
                read_data_o <= sel_q[sel_idx];
            end else begin
                // not ours, host pass-through
                read_data_o <= hm2_data_i;
            end
        end
    end

endmodule

// ==== hdl/pin_mux.sv ====
// open-drain overrides DDR; a select of 72 or more drives a constant 0 source
`timescale 1ns/1ps
`include "gpio_consts.svh"

module pin_mux (
    input  logic                reset_in,
    input  logic                write_address,
    input  gpio_pkg::pin_vec_t  hm3_data_i,
    input  gpio_pkg::pin_vec_t  ddr_i,
    input  gpio_pkg::pin_vec_t  od_i,
    input  gpio_pkg::port_sel_t port_sel_i [`GPIO_NUM_PINS],
    output gpio_pkg::pin_vec_t  pin_out_o,
    output gpio_pkg::pin_vec_t  pin_oe_o
);
    import gpio_pkg::*;

    // every value a select can take
    localparam int SRC_W = 1 << `GPIO_SEL_W;

    // host vector padded with zeros up to the full select range
    logic [SRC_W-1:0] src_ext;
    // source bit picked for each pin
    pin_vec_t         chosen;

    assign src_ext = SRC_W'(hm3_data_i);

    // per-pin source select
    always_comb begin
        for (int p = 0; p < `GPIO_NUM_PINS; p++) begin
            chosen[p] = src_ext[port_sel_i[p]];
        end
    end

    // drive mode, registered
    always_ff @(posedge reset_in or posedge write_address) begin
        if (write_address) begin
            pin_out_o <= '0;
            pin_oe_o  <= '0;
        end else begin
            // open-drain pins only ever pull low
            pin_out_o <= chosen & ~od_i;
            // od: enable when the source is low, otherwise follow DDR
            pin_oe_o  <= (od_i & ~chosen) | (~od_i & ddr_i);
        end
    end

endmodule

// ==== include/gpio_consts.svh ====
// byte addresses, word aligned; bank 3/4 windows and the ADC and touch windows are not decoded
`ifndef GPIO_CONSTS_SVH
`define GPIO_CONSTS_SVH

// host bus
`define GPIO_BUS_W          32
`define GPIO_ADDR_W         16

// two 36-bit banks, flattened
`define GPIO_NUM_PINS       72

// one pin source index
`define GPIO_SEL_W          8

// pins held in one DDR / open-drain / input word
`define GPIO_REG_W          24
`define GPIO_NUM_REGS       3

// four selects per word, 72 / 4
`define GPIO_NUM_SEL_REGS   18

// register windows
`define GPIO_IN_BASE        16'h1000
`define GPIO_DDR_BASE       16'h1100
`define GPIO_SEL_BASE       16'h1120
`define GPIO_OD_BASE        16'h1300

// edges from strobe to commit or read data load
`define GPIO_BUS_LAT        3

`endif

// ==== list.f ====
+incdir+include
hdl/gpio_pkg.sv
hdl/gpio_bus_if.sv
hdl/bus_strobe_sync.sv
hdl/gpio_reg_file.sv
hdl/pin_mux.sv
hdl/gpio_decoder_top.sv
dv/tb_clock.sv
dv/gpio_decoder_properties.sv
dv/gpio_decoder_tb.sv
